/* Bender.yml */
package:
  name: simd_exe_stage

export_include_dirs:
  - design

sources:
  - files:
      - design/simd_pkg.sv
      - design/simd_lane_if.sv
      - design/functional_unit.sv
      - design/simd_unit.sv
      - design/simd_exe_stage.sv
  - target: test
    files:
      - verification/simd_exe_stage_assert.sv
      - verification/simd_exe_stage_tb.sv

/* design/functional_unit.sv */
// One 64-bit lane of the SIMD execute stage
// Works on packed sub-elements of the selected width, carries stay inside each element
`timescale 1ns/100ps

`include "simd_consts.svh"

module functional_unit (
    simd_lane_if.lane lane  // Operands in, lane result out
);
    import simd_pkg::*;

    localparam int NBYTES = `SIMD_DATA_SIZE / 8;

    logic [2:0]                 byte_off_mask;  // Byte offset bits inside one element
    logic [NBYTES-1:0]          byte_eq;
    logic [`SIMD_DATA_SIZE-1:0] arith_res;
    logic [`SIMD_DATA_SIZE-1:0] seq_res;

    // 1, 2, 4 or 8 bytes per element
    assign byte_off_mask = 3'((4'd1 << lane.sew) - 4'd1);

    // Byte-sliced add/sub, the carry chain restarts at each element border
    always_comb begin
        logic       carry;
        logic [7:0] opnd;
        logic [8:0] sum;
        carry = 1'b0;
        opnd = 8'h00;
        sum = 9'h000;
        arith_res = '0;
        for (int b = 0; b < NBYTES; b++) begin
            opnd = (lane.op == VSUB) ? ~lane.vs1[b*8+:8] : lane.vs1[b*8+:8];
            if ((3'(b) & byte_off_mask) == 3'd0) begin
                carry = (lane.op == VSUB);  // +1 completes the two's complement
            end
            sum = {1'b0, lane.vs2[b*8+:8]} + {1'b0, opnd} + {8'h00, carry};
            arith_res[b*8+:8] = sum[7:0];
            carry = sum[8];
        end
    end

    always_comb begin
        for (int b = 0; b < NBYTES; b++) begin
            byte_eq[b] = (lane.vs1[b*8+:8] == lane.vs2[b*8+:8]);
        end
    end

    // Element equal when all of its bytes match, result goes to bit 0 of the element
    always_comb begin
        logic elem_eq;
        elem_eq = 1'b1;
        seq_res = '0;
        for (int b = 0; b < NBYTES; b++) begin
            elem_eq = 1'b1;
            if ((3'(b) & byte_off_mask) == 3'd0) begin
                for (int k = 0; k < NBYTES; k++) begin
                    if ((3'(k) & ~byte_off_mask) == 3'(b)) begin
                        elem_eq = elem_eq & byte_eq[k];
                    end
                end
                seq_res[b*8] = elem_eq;
            end
        end
    end

    always_comb begin
        case (lane.op)
            VADD, VSUB: lane.vd = arith_res;
            VAND:       lane.vd = lane.vs2 & lane.vs1;
            VOR:        lane.vd = lane.vs2 | lane.vs1;
            VXOR:       lane.vd = lane.vs2 ^ lane.vs1;
            VMSEQ:      lane.vd = seq_res;
            default:    lane.vd = '0;  // Scalar-only ops
        endcase
    end

endmodule

/* design/simd_consts.svh */
// Width constants for the SIMD execute stage
// Included by the RTL and the testbench wherever vector sizes are needed
`ifndef SIMD_CONSTS_SVH
`define SIMD_CONSTS_SVH

// Vector register width in bits
`define SIMD_VLEN 128

// Width of one functional unit lane
`define SIMD_DATA_SIZE 64

`define SIMD_VELEMENTS (`SIMD_VLEN / `SIMD_DATA_SIZE)  // Lanes per vector

// One mask bit per byte of the vector
`define SIMD_VMASK_W (`SIMD_VLEN / 8)

`define SIMD_TAG_W 5  // Destination tag carried through the stage

`endif

/* design/simd_exe_stage.sv */
// SIMD execute stage top level
// Issue and output registers around the SIMD core, valid/ready on both sides
`timescale 1ns/100ps

`include "simd_consts.svh"

module simd_exe_stage (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  simd_pkg::simd_op_e         op_i,
    input  simd_pkg::sew_e             sew_i,
    input  simd_pkg::src_e             src_i,
    input  logic [`SIMD_VLEN-1:0]      data_vs1_i,
    input  logic [`SIMD_VLEN-1:0]      data_vs2_i,
    input  logic [`SIMD_DATA_SIZE-1:0] data_rs1_i,
    input  logic [4:0]                 imm_i,
    input  logic [`SIMD_VMASK_W-1:0]   data_vm_i,
    input  logic [`SIMD_VLEN-1:0]      data_old_vd_i,
    input  logic [`SIMD_TAG_W-1:0]     tag_i,
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output logic [`SIMD_TAG_W-1:0]     out_tag_o,
    output logic [`SIMD_VLEN-1:0]      vresult_o,
    output logic [`SIMD_DATA_SIZE-1:0] scalar_o,
    output logic                       vector_we_o,
    output logic                       scalar_we_o
);
    import simd_pkg::*;

    // Issue register
    logic                       iss_valid_q;
    simd_op_e                   iss_op_q;
    sew_e                       iss_sew_q;
    src_e                       iss_src_q;
    logic [`SIMD_VLEN-1:0]      iss_vs1_q;
    logic [`SIMD_VLEN-1:0]      iss_vs2_q;
    logic [`SIMD_DATA_SIZE-1:0] iss_rs1_q;
    logic [4:0]                 iss_imm_q;
    logic [`SIMD_VMASK_W-1:0]   iss_vm_q;
    logic [`SIMD_VLEN-1:0]      iss_old_vd_q;
    logic [`SIMD_TAG_W-1:0]     iss_tag_q;

    // Output register
    logic                       out_valid_q;
    logic                       vector_we_q;
    logic                       scalar_we_q;

    logic [`SIMD_VLEN-1:0]      vresult_d;
    logic [`SIMD_DATA_SIZE-1:0] scalar_d;
    logic                       out_adv;     // Output register can take new data
    logic                       iss_is_scalar;

    assign out_adv    = !out_valid_q || out_ready_i;
    assign in_ready_o = !iss_valid_q || out_adv;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss_valid_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (in_ready_o) iss_valid_q <= in_valid_i;
            if (out_adv) out_valid_q <= iss_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            iss_op_q     <= op_i;
            iss_sew_q    <= sew_i;
            iss_src_q    <= src_i;
            iss_vs1_q    <= data_vs1_i;
            iss_vs2_q    <= data_vs2_i;
            iss_rs1_q    <= data_rs1_i;
            iss_imm_q    <= imm_i;
            iss_vm_q     <= data_vm_i;
            iss_old_vd_q <= data_old_vd_i;
            iss_tag_q    <= tag_i;
        end
    end

    simd_unit u_simd_unit (
        .op_i          (iss_op_q),
        .sew_i         (iss_sew_q),
        .src_i         (iss_src_q),
        .data_vs1_i    (iss_vs1_q),
        .data_vs2_i    (iss_vs2_q),
        .data_old_vd_i (iss_old_vd_q),
        .data_rs1_i    (iss_rs1_q),
        .imm_i         (iss_imm_q),
        .data_vm_i     (iss_vm_q),
        .vresult_o     (vresult_d),
        .scalar_o      (scalar_d)
    );

    assign iss_is_scalar = (iss_op_q == VMV_X_S) || (iss_op_q == VEXT) || (iss_op_q == VCNT);

    // Results held here while the consumer stalls
    always_ff @(posedge clk_i) begin
        if (iss_valid_q && out_adv) begin
            out_tag_o   <= iss_tag_q;
            vresult_o   <= vresult_d;
            scalar_o    <= scalar_d;
            vector_we_q <= !iss_is_scalar;
            scalar_we_q <= iss_is_scalar;
        end
    end

    assign out_valid_o = out_valid_q;
    assign vector_we_o = out_valid_q & vector_we_q;
    assign scalar_we_o = out_valid_q & scalar_we_q;

endmodule

/* design/simd_lane_if.sv */
// Operand and result bundle between the SIMD core and one functional unit
// Purely combinational, one instance per 64-bit lane
`timescale 1ns/100ps

`include "simd_consts.svh"

interface simd_lane_if;
    import simd_pkg::*;

    simd_op_e                   op;
    sew_e                       sew;
    logic [`SIMD_DATA_SIZE-1:0] vs1;
    logic [`SIMD_DATA_SIZE-1:0] vs2;
    logic [`SIMD_DATA_SIZE-1:0] vd;   // Lane result

    // SIMD core side
    modport core (output op, sew, vs1, vs2, input vd);

    // Functional unit side
    modport lane (input op, sew, vs1, vs2, output vd);

endinterface

/* design/simd_pkg.sv */
// Shared types of the SIMD execute stage
// Element width, operand source and opcode encodings
package simd_pkg;

    // Selected element width
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_e;

    // Where the first vector operand comes from
    typedef enum logic [1:0] {
        SRC_VV = 2'b00,  // Vector register vs1
        SRC_VX = 2'b01,  // Scalar rs1, replicated
        SRC_VI = 2'b10   // Sign-extended immediate, replicated
    } src_e;

    // SIMD opcodes
    typedef enum logic [3:0] {
        VADD    = 4'd0,
        VSUB    = 4'd1,  // vs2 - vs1
        VAND    = 4'd2,
        VOR     = 4'd3,
        VXOR    = 4'd4,
        VMSEQ   = 4'd5,  // One per element where equal
        VMV_X_S = 4'd6,  // Element 0 to scalar
        VEXT    = 4'd7,  // Element rs1 to scalar
        VCNT    = 4'd8   // Leading equal elements
    } simd_op_e;

endpackage

/* design/simd_unit.sv */
// Combinational core of the SIMD execute stage
// Replicates the scalar operand, runs the lanes, merges under the byte mask
// and forms the scalar result of move, extract and count
`timescale 1ns/100ps

`include "simd_consts.svh"

module simd_unit (
    input  simd_pkg::simd_op_e      op_i,
    input  simd_pkg::sew_e          sew_i,
    input  simd_pkg::src_e          src_i,
    input  logic [`SIMD_VLEN-1:0]      data_vs1_i,
    input  logic [`SIMD_VLEN-1:0]      data_vs2_i,
    input  logic [`SIMD_VLEN-1:0]      data_old_vd_i,
    input  logic [`SIMD_DATA_SIZE-1:0] data_rs1_i,
    input  logic [4:0]                 imm_i,        // Sign-extended before use
    input  logic [`SIMD_VMASK_W-1:0]   data_vm_i,    // One bit per byte
    output logic [`SIMD_VLEN-1:0]      vresult_o,
    output logic [`SIMD_DATA_SIZE-1:0] scalar_o
);
    import simd_pkg::*;

    localparam int MIDX_W = $clog2(`SIMD_VMASK_W);

    logic [`SIMD_DATA_SIZE-1:0] scalar_src;
    logic [`SIMD_VLEN-1:0]      scalar_rep;
    logic [`SIMD_VLEN-1:0]      vs1_sel;
    logic [`SIMD_VLEN-1:0]      vd_all;       // Unmasked lane results
    simd_op_e                   lane_op;
    logic [MIDX_W-1:0]          byte_off_mask;
    logic                       is_scalar_op;
    logic [`SIMD_DATA_SIZE-1:0] elem_ones;    // Ones over one element width
    logic [6:0]                 ext_shift;
    logic [`SIMD_VLEN-1:0]      ext_vec;
    logic [MIDX_W:0]            elem_cnt;     // Elements per vector
    logic [MIDX_W:0]            lead_cnt;

    assign scalar_src = (src_i == SRC_VX) ? data_rs1_i
                                          : {{(`SIMD_DATA_SIZE-5){imm_i[4]}}, imm_i};

    always_comb begin
        case (sew_i)
            SEW_8:   scalar_rep = {(`SIMD_VLEN/8){scalar_src[7:0]}};
            SEW_16:  scalar_rep = {(`SIMD_VLEN/16){scalar_src[15:0]}};
            SEW_32:  scalar_rep = {(`SIMD_VLEN/32){scalar_src[31:0]}};
            default: scalar_rep = {(`SIMD_VLEN/64){scalar_src}};
        endcase
    end

    assign vs1_sel = (src_i == SRC_VV) ? data_vs1_i : scalar_rep;

    // VCNT needs the compare result of every element
    assign lane_op = (op_i == VCNT) ? VMSEQ : op_i;

    genvar i;
    generate
        for (i = 0; i < `SIMD_VELEMENTS; i++) begin : g_lane
            simd_lane_if lane_if ();

            assign lane_if.op  = lane_op;
            assign lane_if.sew = sew_i;
            assign lane_if.vs1 = vs1_sel[i*`SIMD_DATA_SIZE+:`SIMD_DATA_SIZE];
            assign lane_if.vs2 = data_vs2_i[i*`SIMD_DATA_SIZE+:`SIMD_DATA_SIZE];

            functional_unit u_fu (
                .lane (lane_if.lane)
            );

            assign vd_all[i*`SIMD_DATA_SIZE+:`SIMD_DATA_SIZE] = lane_if.vd;
        end
    endgenerate

    assign byte_off_mask = MIDX_W'((5'd1 << sew_i) - 5'd1);
    assign is_scalar_op  = (op_i == VMV_X_S) || (op_i == VEXT) || (op_i == VCNT);

    // Each byte follows the mask bit of its element's first byte
    always_comb begin
        logic [MIDX_W-1:0] first;
        first = '0;
        vresult_o = data_old_vd_i;
        for (int j = 0; j < `SIMD_VMASK_W; j++) begin
            first = MIDX_W'(j) & ~byte_off_mask;
            if (data_vm_i[first] && !is_scalar_op) begin
                vresult_o[j*8+:8] = vd_all[j*8+:8];
            end
        end
    end

    always_comb begin
        case (sew_i)
            SEW_8:   elem_ones = 64'h0000_0000_0000_00ff;
            SEW_16:  elem_ones = 64'h0000_0000_0000_ffff;
            SEW_32:  elem_ones = 64'h0000_0000_ffff_ffff;
            default: elem_ones = '1;
        endcase
    end

    assign elem_cnt  = (MIDX_W+1)'(`SIMD_VMASK_W) >> sew_i;
    assign ext_shift = 7'({data_rs1_i[3:0], 3'b000} << sew_i);  // Bit offset of element rs1
    assign ext_vec   = data_vs2_i >> ext_shift;

    // Count of equal elements from index 0, stops at the first mismatch
    always_comb begin
        logic found_zero;
        found_zero = 1'b0;
        lead_cnt = '0;
        for (int j = 0; j < `SIMD_VMASK_W; j++) begin
            if ((MIDX_W'(j) & byte_off_mask) == '0) begin
                if (!vd_all[j*8]) begin
                    found_zero = 1'b1;
                end else if (!found_zero) begin
                    lead_cnt = lead_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (op_i)
            VMV_X_S: scalar_o = data_vs2_i[`SIMD_DATA_SIZE-1:0] & elem_ones;
            VEXT: begin
                if (data_rs1_i >= `SIMD_DATA_SIZE'(elem_cnt)) begin
                    scalar_o = '0;  // Index past the last element
                end else begin
                    scalar_o = ext_vec[`SIMD_DATA_SIZE-1:0] & elem_ones;
                end
            end
            VCNT:    scalar_o = `SIMD_DATA_SIZE'(lead_cnt);
            default: scalar_o = '0;
        endcase
    end

endmodule

/* flist.f */
+incdir+design
design/simd_pkg.sv
design/simd_lane_if.sv
design/functional_unit.sv
design/simd_unit.sv
design/simd_exe_stage.sv
verification/simd_exe_stage_assert.sv
verification/simd_exe_stage_tb.sv

/* verification/simd_exe_stage_assert.sv */
// Concurrent checks on the output handshake of the SIMD execute stage
// Bound to the top level by the bind at the end of this file
`timescale 1ns/100ps

`include "simd_consts.svh"

module simd_exe_stage_assert (
    input logic                       clk_i,
    input logic                       arst_n_i,
    input logic                       in_ready_i,
    input logic                       out_valid_i,
    input logic                       out_ready_i,
    input logic [`SIMD_TAG_W-1:0]     out_tag_i,
    input logic [`SIMD_VLEN-1:0]      vresult_i,
    input logic [`SIMD_DATA_SIZE-1:0] scalar_i,
    input logic                       vector_we_i,
    input logic                       scalar_we_i
);

    a_idle_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_i)
        else $error("out_valid_o high while reset is asserted");

    // Stalled output must not change
    a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_tag_i)
            && $stable(vresult_i) && $stable(scalar_i)
            && $stable(vector_we_i) && $stable(scalar_we_i))
        else $error("Output payload changed while stalled");

    a_one_we: assert property (@(posedge clk_i) !(vector_we_i && scalar_we_i))
        else $error("vector_we_o and scalar_we_o both high");

    a_ready_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(in_ready_i))
        else $error("in_ready_o unknown outside reset");

endmodule

bind simd_exe_stage simd_exe_stage_assert u_assert (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_tag_i   (out_tag_o),
    .vresult_i   (vresult_o),
    .scalar_i    (scalar_o),
    .vector_we_i (vector_we_o),
    .scalar_we_i (scalar_we_o)
);

/* verification/simd_exe_stage_tb.sv */
// Directed testbench of the SIMD execute stage
// Sends instructions over valid/ready and checks every result against a reference model
`timescale 1ns/100ps

`include "simd_consts.svh"

module simd_exe_stage_tb;
    import simd_pkg::*;

    logic                       clk_i;
    logic                       arst_n_i;
    logic                       in_valid_i;
    logic                       in_ready_o;
    simd_op_e                   op_i;
    sew_e                       sew_i;
    src_e                       src_i;
    logic [`SIMD_VLEN-1:0]      data_vs1_i;
    logic [`SIMD_VLEN-1:0]      data_vs2_i;
    logic [`SIMD_DATA_SIZE-1:0] data_rs1_i;
    logic [4:0]                 imm_i;
    logic [`SIMD_VMASK_W-1:0]   data_vm_i;
    logic [`SIMD_VLEN-1:0]      data_old_vd_i;
    logic [`SIMD_TAG_W-1:0]     tag_i;
    logic                       out_valid_o;
    logic                       out_ready_i;
    logic [`SIMD_TAG_W-1:0]     out_tag_o;
    logic [`SIMD_VLEN-1:0]      vresult_o;
    logic [`SIMD_DATA_SIZE-1:0] scalar_o;
    logic                       vector_we_o;
    logic                       scalar_we_o;

    logic [31:0]            rnd_st;
    logic [31:0]            rdy_st;      // Separate stream for out_ready_i
    logic                   rand_ready;
    logic [`SIMD_TAG_W-1:0] tag_ctr;

    // Expected results in issue order
    logic [`SIMD_TAG_W-1:0]     exp_tag[$];
    logic [`SIMD_VLEN-1:0]      exp_vres[$];
    logic [`SIMD_DATA_SIZE-1:0] exp_scal[$];
    logic                       exp_vwe[$];

    simd_exe_stage DUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rnd_st = xorshift(rnd_st);
        return rnd_st;
    endfunction

    function automatic logic [`SIMD_VLEN-1:0] rand128();
        return {rand32(), rand32(), rand32(), rand32()};
    endfunction

    function automatic logic is_vec(input simd_op_e op);
        return !(op == VMV_X_S || op == VEXT || op == VCNT);
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // Reference model that works element by element on the op, mask and scalar rules
    task automatic model(input simd_op_e op, input sew_e sew, input src_e src,
                         input logic [127:0] vs1, input logic [127:0] vs2,
                         input logic [127:0] old_vd, input logic [63:0] rs1,
                         input logic [4:0] imm, input logic [15:0] vm,
                         output logic [127:0] vres, output logic [63:0] scal);
        int          ew;
        int          ne;
        logic [63:0] emask;
        logic [63:0] sx;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic        lead;
        ew = 8 << sew;
        ne = `SIMD_VLEN / ew;
        emask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        sx = (src == SRC_VX) ? rs1 : {{59{imm[4]}}, imm};
        vres = old_vd;
        scal = '0;
        lead = 1'b1;
        for (int e = 0; e < ne; e++) begin
            a = (vs2 >> (e * ew)) & emask;
            b = (src == SRC_VV) ? ((vs1 >> (e * ew)) & emask) : (sx & emask);
            case (op)
                VADD:    r = a + b;
                VSUB:    r = a - b;
                VAND:    r = a & b;
                VOR:     r = a | b;
                VXOR:    r = a ^ b;
                VMSEQ:   r = (a == b) ? 64'd1 : 64'd0;
                default: r = '0;
            endcase
            r = r & emask;  // Drops the carry out of the element
            if (is_vec(op) && vm[e * ew / 8]) begin
                vres = (vres & ~({64'd0, emask} << (e * ew))) | ({64'd0, r} << (e * ew));
            end
            if (op == VCNT && lead) begin
                if (a == b) scal = scal + 64'd1;
                else lead = 1'b0;
            end
        end
        if (op == VMV_X_S) scal = vs2[63:0] & emask;
        if (op == VEXT) scal = (rs1 >= 64'(ne)) ? '0 : (vs2 >> (rs1[3:0] * ew)) & emask;
    endtask

    task automatic issue(input simd_op_e op, input sew_e sew, input src_e src,
                         input logic [127:0] vs1, input logic [127:0] vs2,
                         input logic [63:0] rs1, input logic [4:0] imm, input logic [15:0] vm);
        logic [`SIMD_VLEN-1:0]      old_vd;
        logic [`SIMD_VLEN-1:0]      ev;
        logic [`SIMD_DATA_SIZE-1:0] es;
        int                         waited;
        old_vd = rand128();
        model(op, sew, src, vs1, vs2, old_vd, rs1, imm, vm, ev, es);
        exp_tag.push_back(tag_ctr);
        exp_vres.push_back(ev);
        exp_scal.push_back(es);
        exp_vwe.push_back(is_vec(op));
        in_valid_i    = 1'b1;
        op_i          = op;
        sew_i         = sew;
        src_i         = src;
        data_vs1_i    = vs1;
        data_vs2_i    = vs2;
        data_rs1_i    = rs1;
        imm_i         = imm;
        data_vm_i     = vm;
        data_old_vd_i = old_vd;
        tag_i         = tag_ctr;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!in_ready_o && waited < 100);
        if (!in_ready_o) fail_stop("Timeout: in_ready_o stayed low for 100 cycles");
        @(posedge clk_i);  // Transfer edge
        #1;
        in_valid_i = 1'b0;
        tag_ctr++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_tag.size() != 0 && waited < 500) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_tag.size() != 0) fail_stop("Timeout: results still missing after 500 cycles");
        // No further result may follow the last expected one
        repeat (2) @(negedge clk_i);
        compare("out_valid_o", out_valid_o, 1'b0);
        @(posedge clk_i);
        #1;
    endtask

    task automatic test_reset();
        @(negedge clk_i);
        compare("out_valid_o", out_valid_o, 1'b0);
        compare("in_ready_o", in_ready_o, 1'b1);
        @(posedge clk_i);
        #1;
    endtask

    // Random, carry-heavy and equal operands for every vector op, width and source
    task automatic test_vector_ops();
        logic [127:0] a;
        logic [127:0] b;
        logic [63:0]  rs1;
        logic [4:0]   im;
        for (int op = 0; op <= 5; op++) begin
            for (int sew = 0; sew < 4; sew++) begin
                for (int src = 0; src < 3; src++) begin
                    for (int k = 0; k < 3; k++) begin
                        a = rand128();
                        b = rand128();
                        rs1 = {rand32(), rand32()};
                        im = rs1[12:8];
                        if (k == 1) begin
                            a = {16{8'h01}};
                            b = (op == 1) ? '0 : '1;  // Wraps inside every element
                            rs1 = 64'd1;
                            im = 5'd1;
                        end else if (k == 2) begin
                            a = b;
                            rs1 = b[63:0];
                            im = b[4:0];
                        end
                        issue(simd_op_e'(op), sew_e'(sew), src_e'(src), a, b, rs1, im, '1);
                    end
                end
            end
        end
        drain();
    endtask

    task automatic test_mask();
        for (int sew = 0; sew < 4; sew++) begin
            for (int k = 0; k < 4; k++) begin
                issue(k[0] ? VXOR : VADD, sew_e'(sew), SRC_VV, rand128(), rand128(),
                      {rand32(), rand32()}, 5'd3, 16'(rand32()));
            end
        end
        drain();
    endtask

    task automatic test_scalar();
        logic [127:0] v;
        logic [127:0] w;
        int           ne;
        for (int sew = 0; sew < 4; sew++) begin
            ne = 16 >> sew;
            v = rand128();
            issue(VMV_X_S, sew_e'(sew), SRC_VV, rand128(), v, 64'd0, 5'd0, '1);
            issue(VEXT, sew_e'(sew), SRC_VV, rand128(), v, 64'(rand32() % ne), 5'd0, '1);
            issue(VEXT, sew_e'(sew), SRC_VV, rand128(), v, 64'(ne), 5'd0, '1);
            issue(VEXT, sew_e'(sew), SRC_VV, rand128(), v, {rand32(), rand32()} | 64'h100,
                  5'd0, '1);
            // Element c is the first that differs
            for (int c = 0; c <= ne; c++) begin
                w = v;
                if (c < ne) w[c * (8 << sew)] = ~w[c * (8 << sew)];
                issue(VCNT, sew_e'(sew), SRC_VV, w, v, 64'd0, 5'd0, '1);
            end
        end
        drain();
    endtask

    task automatic test_stream();
        logic [31:0] r;
        logic [63:0] rs1;
        rand_ready = 1'b1;
        for (int n = 0; n < 60; n++) begin
            r = rand32();
            rs1 = r[4] ? {rand32(), rand32()} : 64'(r[9:5]);  // Small values hit VEXT range
            issue(simd_op_e'(r[3:0] % 9), sew_e'(r[11:10]), src_e'(r[13:12] % 3),
                  rand128(), rand128(), rs1, r[18:14], r[31:16]);
        end
        drain();
        rand_ready = 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Consumer stalls at random only in the stream test
    initial begin
        forever begin
            @(posedge clk_i);
            #1;
            if (rand_ready) begin
                rdy_st = xorshift(rdy_st);
                out_ready_i = rdy_st[3];
            end else begin
                out_ready_i = 1'b1;
            end
        end
    end

    // Checks every result that leaves the DUT
    initial begin
        logic [`SIMD_VLEN-1:0] ev;
        logic                  vwe;
        forever begin
            @(negedge clk_i);
            if (arst_n_i && out_valid_o && out_ready_i) begin
                if (exp_tag.size() == 0) fail_stop("Result seen with no instruction pending");
                vwe = exp_vwe.pop_front();
                ev = exp_vres.pop_front();
                compare("out_tag_o", out_tag_o, exp_tag.pop_front());
                if (vwe) compare("vresult_o", vresult_o, ev);
                compare("scalar_o", scalar_o, exp_scal.pop_front());
                compare("vector_we_o", vector_we_o, vwe);
                compare("scalar_we_o", scalar_we_o, !vwe);
            end
        end
    end

    initial begin
        rnd_st        = 32'h27be;
        rdy_st        = ~32'h27be;
        rand_ready    = 1'b0;
        tag_ctr       = '0;
        arst_n_i      = 1'b0;
        in_valid_i    = 1'b0;
        op_i          = VADD;
        sew_i         = SEW_8;
        src_i         = SRC_VV;
        data_vs1_i    = '0;
        data_vs2_i    = '0;
        data_rs1_i    = '0;
        imm_i         = '0;
        data_vm_i     = '0;
        data_old_vd_i = '0;
        tag_i         = '0;
        out_ready_i   = 1'b1;
        repeat (16) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        test_reset();
        test_vector_ops();
        test_mask();
        test_scalar();
        test_stream();
        $display("TEST OK");
        $finish;
    end

endmodule
